// ==== core_pkg.sv ====
/* shared widths, RV32 opcode fields and the pipeline structs of the core
   every stage and the top level take what they need from here */
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t PC_STEP  = 32'd4;

    // major opcodes used by the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

    // ebreak is a single fixed encoding
    localparam word_t EBREAK_WORD = 32'h0010_0073;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, ADDI, LUI, BEQ, BNE, JAL, EBREAK, NOP
    } op_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_t       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      we;
        word_t     imm;
        word_t     rs1_data;
        word_t     rs2_data;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     result;
        logic      halt;
    } ex_wb_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      flush_if;
        logic      flush_id;
        logic      flush_ex;
        logic      stop_fetch;
        redirect_t redirect;
    } pipe_ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     data;
    } commit_t;

endpackage

// ==== regfile.sv ====
/* integer register file, two combinational reads and one write per cycle
   a write in the same cycle is passed straight to a matching read */
module regfile (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t    wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::word_t    rdata1_o,
    output core_pkg::word_t    rdata2_o
);
    import core_pkg::*;

    word_t regs_q [32];
    logic  wr_en;

    // x0 is never written
    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

// ==== fetch_stage.sv ====
/* program counter and instruction port, one fetch in flight at a time
   a redirect during a pending fetch drops its response and is requested next */
module fetch_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  core_pkg::pipe_ctrl_t pipe_ctrl_i,
    output logic                 req_valid_o,
    output core_pkg::word_t      req_addr_o,
    input  logic                 resp_valid_i,
    input  core_pkg::word_t      resp_instr_i,
    output core_pkg::if_id_t     if_id_o
);
    import core_pkg::*;

    logic   req_valid_q;
    word_t  req_addr_q;
    logic   drop_q;
    word_t  redir_pc_q;
    logic   fetch_done;
    if_id_t if_id_q;

    assign fetch_done = req_valid_q && resp_valid_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            req_valid_q <= 1'b0;
            req_addr_q  <= RESET_PC;
            drop_q      <= 1'b0;
        end else if (!req_valid_q) begin
            // idle after reset, or stopped for good once halted
            if (!pipe_ctrl_i.stop_fetch) begin
                req_valid_q <= 1'b1;
                if (pipe_ctrl_i.redirect.valid) begin
                    req_addr_q <= pipe_ctrl_i.redirect.target;
                end
            end
        end else if (fetch_done) begin
            req_valid_q <= !pipe_ctrl_i.stop_fetch;
            drop_q      <= 1'b0;
            if (pipe_ctrl_i.redirect.valid) begin
                req_addr_q <= pipe_ctrl_i.redirect.target;
            end else if (drop_q) begin
                req_addr_q <= redir_pc_q;
            end else begin
                req_addr_q <= req_addr_q + PC_STEP;
            end
        end else if (pipe_ctrl_i.redirect.valid) begin
            // address must stay put, so park the target
            drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pipe_ctrl_i.redirect.valid) begin
            redir_pc_q <= pipe_ctrl_i.redirect.target;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            if_id_q <= '0;
        end else begin
            if_id_q.valid <= fetch_done && !drop_q && !pipe_ctrl_i.flush_if;
            if_id_q.pc    <= req_addr_q;
            if_id_q.instr <= resp_instr_i;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_addr_o  = req_addr_q;
    assign if_id_o     = if_id_q;

endmodule

// ==== decode_stage.sv ====
/* decodes one instruction per cycle and reads its source registers
   jal is resolved here, everything else is passed to execute */
module decode_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  core_pkg::pipe_ctrl_t pipe_ctrl_i,
    input  core_pkg::if_id_t     if_id_i,
    output core_pkg::reg_addr_t  rs1_addr_o,
    output core_pkg::reg_addr_t  rs2_addr_o,
    input  core_pkg::word_t      rs1_data_i,
    input  core_pkg::word_t      rs2_data_i,
    output core_pkg::redirect_t  id_redirect_o,
    output core_pkg::id_ex_t     id_ex_o
);
    import core_pkg::*;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    op_t        op;
    word_t      imm;
    logic       writes_rd;
    id_ex_t     id_ex_q;

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op  = NOP;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == FUNCT7_BASE) begin
                    case (funct3)
                        3'b000:  op = ADD;
                        3'b100:  op = XOR;
                        3'b110:  op = OR;
                        3'b111:  op = AND;
                        default: op = NOP;
                    endcase
                end else if (funct7 == FUNCT7_SUB && funct3 == 3'b000) begin
                    op = SUB;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    op  = ADDI;
                    imm = imm_i;
                end
            end
            OPC_LUI: begin
                op  = LUI;
                imm = imm_u;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    op = BEQ;
                end else if (funct3 == 3'b001) begin
                    op = BNE;
                end
            end
            OPC_JAL: begin
                op  = JAL;
                imm = imm_j;
            end
            default: begin
                if (instr == EBREAK_WORD) begin
                    op = EBREAK;
                end
            end
        endcase
    end

    // only real results with a nonzero destination touch the register file
    assign writes_rd = (op inside {ADD, SUB, AND, OR, XOR, ADDI, LUI, JAL}) && (rd != '0);

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign id_redirect_o.valid  = if_id_i.valid && (op == JAL);
    assign id_redirect_o.target = if_id_i.pc + imm_j;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.valid    <= if_id_i.valid && !pipe_ctrl_i.flush_id;
            id_ex_q.pc       <= if_id_i.pc;
            id_ex_q.op       <= op;
            id_ex_q.rd       <= rd;
            id_ex_q.rs1      <= rs1_addr_o;
            id_ex_q.rs2      <= rs2_addr_o;
            id_ex_q.we       <= writes_rd;
            id_ex_q.imm      <= imm;
            id_ex_q.rs1_data <= rs1_data_i;
            id_ex_q.rs2_data <= rs2_data_i;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// ==== exec_stage.sv ====
/* execute stage with writeback bypass, ALU and branch resolution
   the result is registered and becomes the writeback entry */
module exec_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  core_pkg::pipe_ctrl_t pipe_ctrl_i,
    input  core_pkg::id_ex_t     id_ex_i,
    input  core_pkg::ex_wb_t     wb_i,
    output core_pkg::redirect_t  ex_redirect_o,
    output core_pkg::ex_wb_t     ex_wb_o
);
    import core_pkg::*;

    logic   wb_fwd_ok;
    word_t  op_a;
    word_t  op_b;
    word_t  result;
    logic   operands_eq;
    logic   taken;
    ex_wb_t ex_wb_q;

    // the writeback entry is the only producer that can be newer than the regfile read
    assign wb_fwd_ok = wb_i.valid && wb_i.we;

    assign op_a = (wb_fwd_ok && wb_i.rd == id_ex_i.rs1) ? wb_i.result : id_ex_i.rs1_data;
    assign op_b = (wb_fwd_ok && wb_i.rd == id_ex_i.rs2) ? wb_i.result : id_ex_i.rs2_data;

    always_comb begin
        case (id_ex_i.op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            ADDI:    result = op_a + id_ex_i.imm;
            LUI:     result = id_ex_i.imm;
            // link value
            JAL:     result = id_ex_i.pc + PC_STEP;
            default: result = '0;
        endcase
    end

    assign operands_eq = (op_a == op_b);

    always_comb begin
        taken = 1'b0;
        if (id_ex_i.valid) begin
            if (id_ex_i.op == BEQ) begin
                taken = operands_eq;
            end else if (id_ex_i.op == BNE) begin
                taken = !operands_eq;
            end
        end
    end

    assign ex_redirect_o.valid  = taken;
    assign ex_redirect_o.target = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            ex_wb_q <= '0;
        end else begin
            ex_wb_q.valid  <= id_ex_i.valid && !pipe_ctrl_i.flush_ex;
            ex_wb_q.pc     <= id_ex_i.pc;
            ex_wb_q.rd     <= id_ex_i.rd;
            ex_wb_q.we     <= id_ex_i.we;
            ex_wb_q.result <= result;
            ex_wb_q.halt   <= id_ex_i.valid && (id_ex_i.op == EBREAK);
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

// ==== control_unit.sv ====
/* picks the redirect for fetch, raises the stage flushes and keeps the halt state
   an ebreak reaching writeback stops the core until reset */
module control_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  core_pkg::redirect_t  id_redirect_i,
    input  core_pkg::redirect_t  ex_redirect_i,
    input  logic                 wb_halt_i,
    output core_pkg::pipe_ctrl_t pipe_ctrl_o,
    output logic                 halt_o
);
    logic halt_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            halt_q <= 1'b0;
        end else if (wb_halt_i) begin
            halt_q <= 1'b1;
        end
    end

    // visible in the same cycle the ebreak commits
    assign halt_o = halt_q || wb_halt_i;

    always_comb begin
        pipe_ctrl_o = '0;
        if (halt_o) begin
            // everything younger than the ebreak is thrown away
            pipe_ctrl_o.flush_if   = 1'b1;
            pipe_ctrl_o.flush_id   = 1'b1;
            pipe_ctrl_o.flush_ex   = 1'b1;
            pipe_ctrl_o.stop_fetch = 1'b1;
        end else if (ex_redirect_i.valid) begin
            // older instruction, wins over a jal in decode
            pipe_ctrl_o.flush_if = 1'b1;
            pipe_ctrl_o.flush_id = 1'b1;
            pipe_ctrl_o.redirect = ex_redirect_i;
        end else if (id_redirect_i.valid) begin
            pipe_ctrl_o.flush_if = 1'b1;
            pipe_ctrl_o.redirect = id_redirect_i;
        end
    end

endmodule

// ==== datapath.sv ====
/* top level of the core: fetch, decode, execute and writeback around the control unit
   fetches over a request/response strobe pair and reports each retired instruction */
module datapath (
    input  logic              clk_i,
    input  logic              rstn_i,
    output logic              req_valid_o,
    output core_pkg::word_t   req_addr_o,
    input  logic              resp_valid_i,
    input  core_pkg::word_t   resp_instr_i,
    output core_pkg::commit_t commit_o,
    output logic              halt_o
);
    import core_pkg::*;

    pipe_ctrl_t pipe_ctrl;
    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_wb_t     ex_wb;
    redirect_t  id_redirect;
    redirect_t  ex_redirect;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       wb_we;

    control_unit control_unit_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .id_redirect_i (id_redirect),
        .ex_redirect_i (ex_redirect),
        .wb_halt_i     (ex_wb.valid && ex_wb.halt),
        .pipe_ctrl_o   (pipe_ctrl),
        .halt_o        (halt_o)
    );

    fetch_stage fetch_stage_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .pipe_ctrl_i  (pipe_ctrl),
        .req_valid_o  (req_valid_o),
        .req_addr_o   (req_addr_o),
        .resp_valid_i (resp_valid_i),
        .resp_instr_i (resp_instr_i),
        .if_id_o      (if_id)
    );

    decode_stage decode_stage_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .pipe_ctrl_i   (pipe_ctrl),
        .if_id_i       (if_id),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .id_redirect_o (id_redirect),
        .id_ex_o       (id_ex)
    );

    // writeback happens straight out of the execute register
    assign wb_we = ex_wb.valid && ex_wb.we;

    regfile regfile_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_we),
        .waddr_i  (ex_wb.rd),
        .wdata_i  (ex_wb.result),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    exec_stage exec_stage_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .pipe_ctrl_i   (pipe_ctrl),
        .id_ex_i       (id_ex),
        .wb_i          (ex_wb),
        .ex_redirect_o (ex_redirect),
        .ex_wb_o       (ex_wb)
    );

    assign commit_o.valid = ex_wb.valid;
    assign commit_o.pc    = ex_wb.pc;
    assign commit_o.rd    = ex_wb.rd;
    assign commit_o.we    = wb_we;
    assign commit_o.data  = ex_wb.result;

endmodule

// ==== datapath_assert.sv ====
/* concurrent checks on the instruction port, halt and commit alignment
   attached to the core top level by the bind below */
module datapath_assert (
    input logic              clk_i,
    input logic              rstn_i,
    input logic              req_valid_i,
    input core_pkg::word_t   req_addr_i,
    input logic              resp_valid_i,
    input core_pkg::commit_t commit_i,
    input logic              halt_i
);
    import core_pkg::*;

    // a pending request keeps its address until the response
    req_addr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i && !resp_valid_i |=> req_valid_i && $stable(req_addr_i))
        else $error("request address changed while pending");

    // once halted and idle, no new request may start
    no_req_after_halt: assert property (@(posedge clk_i) disable iff (!rstn_i)
        halt_i && !req_valid_i |=> !req_valid_i)
        else $error("request started after halt");

    commit_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_i.valid |-> commit_i.pc[1:0] == 2'b00)
        else $error("commit pc not word aligned");

endmodule

bind datapath datapath_assert datapath_assert_inst (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_valid_i  (req_valid_o),
    .req_addr_i   (req_addr_o),
    .resp_valid_i (resp_valid_i),
    .commit_i     (commit_o),
    .halt_i       (halt_o)
);

// ==== tb_datapath.sv ====
/* testbench for the pipelined core with program and expected commits taken from
   datapath_input.txt and an instruction memory that answers with random latency */
module tb_datapath;
    import core_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int WAIT_LIMIT   = 100;
    localparam int QUIET_CYCLES = 40;
    localparam int NUM_RUNS     = 3;

    logic    clk_i;
    logic    rstn_i;
    logic    req_valid_o;
    word_t   req_addr_o;
    logic    resp_valid_i;
    word_t   resp_instr_i;
    commit_t commit_o;
    logic    halt_o;

    word_t mem [MEM_WORDS];
    int    exp_group [$];
    word_t exp_pc [$];
    word_t exp_rd [$];
    word_t exp_we [$];
    word_t exp_data [$];

    integer seed;
    logic   busy;
    int     wait_left;
    int     lat_count [4];
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     run_errors;
    bit     loaded;

    datapath datapath_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_o  (req_valid_o),
        .req_addr_o   (req_addr_o),
        .resp_valid_i (resp_valid_i),
        .resp_instr_i (resp_instr_i),
        .commit_o     (commit_o),
        .halt_o       (halt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // instruction memory model answers each request after 1 to 4 cycles
    always @(posedge clk_i, negedge rstn_i) begin
        int lat;
        if (!rstn_i) begin
            resp_valid_i <= 1'b0;
            busy         <= 1'b0;
            wait_left    <= 0;
        end else if (resp_valid_i) begin
            resp_valid_i <= 1'b0;
            busy         <= 1'b0;
        end else if (busy) begin
            if (wait_left == 0) begin
                resp_valid_i <= 1'b1;
                resp_instr_i <= mem[req_addr_o[9:2]];
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (req_valid_o) begin
            lat = 1 + ($random(seed) & 3);
            lat_count[lat-1] = lat_count[lat-1] + 1;
            busy <= 1'b1;
            if (lat == 1) begin
                resp_valid_i <= 1'b1;
                resp_instr_i <= mem[req_addr_o[9:2]];
            end else begin
                wait_left <= lat - 2;
            end
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic string test_name(input int group);
        case (group)
            1:       return "alu operations";
            2:       return "dependences and x0";
            3:       return "branches";
            4:       return "jal";
            default: return "ebreak halt";
        endcase
    endfunction

    task automatic load_input(output bit ok);
        int    fd;
        string line;
        word_t a;
        word_t w;
        int    g;
        word_t pc;
        word_t rd;
        word_t we;
        word_t data;
        ok = 1'b0;
        // fill pattern is addi x0, x0, index so any stray fetch is harmless
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (word_t'(i) << 20) | 32'h0000_0013;
        end
        fd = $fopen("datapath_input.txt", "r");
        if (fd == 0) begin
            $display("could not open datapath_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) == 8'h4D) begin
                    void'($sscanf(line, "M %h %h", a, w));
                    mem[a[9:2]] = w;
                end else if (line.len() > 0 && line.getc(0) == 8'h43) begin
                    void'($sscanf(line, "C %d %h %h %h %h", g, pc, rd, we, data));
                    exp_group.push_back(g);
                    exp_pc.push_back(pc);
                    exp_rd.push_back(rd);
                    exp_we.push_back(we);
                    exp_data.push_back(data);
                end
            end
            $fclose(fd);
            if (exp_pc.size() == 0) begin
                $display("no expected commits found in datapath_input.txt");
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        // outputs stay quiet while reset is held
        @(negedge clk_i);
        check_value("req_valid_o", word_t'(req_valid_o), 32'd0);
        check_value("commit_o.valid", word_t'(commit_o.valid), 32'd0);
        check_value("halt_o", word_t'(halt_o), 32'd0);
        @(posedge clk_i);
        rstn_i <= 1'b1;
        // first request goes out on the edge after release
        @(negedge clk_i);
        @(negedge clk_i);
        check_value("req_valid_o", word_t'(req_valid_o), 32'd1);
        check_value("req_addr_o", req_addr_o, RESET_PC);
    endtask

    task automatic wait_commit(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk_i);
            if (commit_o.valid) begin
                seen = 1'b1;
            end
        end
    endtask

    // after ebreak nothing else may retire
    task automatic check_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk_i);
            if (commit_o.valid) begin
                $display("commit at pc %h after halt", commit_o.pc);
                errors++;
            end
            if (!halt_o) begin
                $display("halt_o dropped after ebreak");
                errors++;
            end
        end
    endtask

    task automatic run_program(input int run);
        int idx;
        int group;
        int start;
        bit seen;
        idx = 0;
        apply_reset();
        while (idx < exp_pc.size()) begin
            group = exp_group[idx];
            start = errors;
            while (idx < exp_pc.size() && exp_group[idx] == group) begin
                wait_commit(seen);
                if (!seen) begin
                    $display("timeout waiting for commit at pc %h", exp_pc[idx]);
                    errors++;
                    tests_run++;
                    tests_failed++;
                    return;
                end
                check_value("commit_o.pc", commit_o.pc, exp_pc[idx]);
                check_value("commit_o.we", word_t'(commit_o.we), exp_we[idx]);
                if (exp_we[idx] != 0) begin
                    check_value("commit_o.rd", word_t'(commit_o.rd), exp_rd[idx]);
                    check_value("commit_o.data", commit_o.data, exp_data[idx]);
                end
                check_value("halt_o", word_t'(halt_o), (group == 5) ? 32'd1 : 32'd0);
                idx++;
            end
            if (group == 5) begin
                check_quiet();
            end
            tests_run++;
            if (errors != start) begin
                tests_failed++;
            end
            $display("run %0d test %0d %s: %s", run, group, test_name(group),
                     (errors == start) ? "ok" : "FAIL");
        end
    endtask

    initial begin
        rstn_i       <= 1'b0;
        resp_valid_i <= 1'b0;
        resp_instr_i <= '0;
        seed         = 28836;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 4; i++) begin
            lat_count[i] = 0;
        end
        load_input(loaded);
        if (!loaded) begin
            errors++;
        end else begin
            for (int r = 1; r <= NUM_RUNS; r++) begin
                run_program(r);
            end
            // every latency from 1 to 4 has to occur at least once
            for (int i = 0; i < 4; i++) begin
                if (lat_count[i] == 0) begin
                    $display("fetch latency of %0d cycles was never drawn", i + 1);
                    errors++;
                end
            end
        end
        run_errors = errors;
        tests_run++;
        if (run_errors != 0) begin
            tests_failed++;
        end
        $display("test 6 random fetch latency over %0d runs (1:%0d 2:%0d 3:%0d 4:%0d): %s",
                 NUM_RUNS, lat_count[0], lat_count[1], lat_count[2], lat_count[3],
                 (run_errors == 0) ? "ok" : "FAIL");
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== datapath_input.txt ====
# M <byte address> <instruction word>, program image
# C <test> <pc> <rd> <we> <data>, expected commits in order, all hex except test
M 00 00500093
M 04 00C00113
M 08 002081B3
M 0C 40118233
M 10 0021E2B3
M 14 0042F333
M 18 005343B3
M 1C 12345437
M 20 67840413
M 24 00708013
M 28 001004B3
M 2C 40948533
M 30 FFF50593
M 34 00208463
M 38 00209663
M 3C 00100613
M 40 00200613
M 44 00050463
M 48 00300613
M 4C 00400613
M 50 00C006EF
M 54 00100713
M 58 00200713
M 5C 00C687B3
M 60 00100073
M 64 00100813
C 1 00 01 1 00000005
C 1 04 02 1 0000000C
C 1 08 03 1 00000011
C 1 0C 04 1 0000000C
C 1 10 05 1 0000001D
C 1 14 06 1 0000000C
C 1 18 07 1 00000011
C 1 1C 08 1 12345000
C 1 20 08 1 12345678
C 2 24 00 0 00000000
C 2 28 09 1 00000005
C 2 2C 0A 1 00000000
C 2 30 0B 1 FFFFFFFF
C 3 34 00 0 00000000
C 3 38 00 0 00000000
C 3 44 00 0 00000000
C 3 4C 0C 1 00000004
C 4 50 0D 1 00000054
C 4 5C 0F 1 00000058
C 5 60 00 0 00000000

// ==== build.f ====
core_pkg.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
control_unit.sv
datapath.sv
datapath_assert.sv
tb_datapath.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator, result taken from sim.log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_datapath -f build.f \
    -Mdir obj_dir -o tb_datapath_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_datapath_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
